//--- include/pipe_consts.svh
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define ALU_OP_W    5
`define BR_SEL_W    3

`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

`define OP1_RS1     1'b0
`define OP1_PC      1'b1
`define OP2_RS2     1'b0
`define OP2_IMM     1'b1

`define ALU_ADD     5'd0
`define ALU_SUB     5'd1
`define ALU_AND     5'd2
`define ALU_OR      5'd3
`define ALU_XOR     5'd4
`define ALU_SLL     5'd5
`define ALU_SRL     5'd6
`define ALU_SRA     5'd7
`define ALU_SLT     5'd8
`define ALU_SLTU    5'd9
`define ALU_PASS_B  5'd10

// Conditional branch codes equal the branch funct3.
`define BR_BEQ      3'b000
`define BR_BNE      3'b001
`define BR_NONE     3'b010
`define BR_JUMP     3'b011
`define BR_BLT      3'b100
`define BR_BGE      3'b101
`define BR_BLTU     3'b110
`define BR_BGEU     3'b111

`endif

//--- project.f
+incdir+include
verilog/pipe_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/id_ex_stage_reg.sv
verilog/ex_alu.sv
verilog/id_ex_top.sv
sim/id_ex_properties.sv
sim/id_ex_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ID/EX testbench with Verilator.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module id_ex_tb -Mdir "$OBJ_DIR" -o id_ex_sim -f project.f; then
    echo "Verilator build failed."
    exit 1
fi

"./$OBJ_DIR/id_ex_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status."
    exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG."
exit 1

//--- sim/id_ex_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module id_ex_properties import pipe_pkg::*; (
    input logic   clk_i,
    input logic   rst_n_i,
    input logic   stall_i,
    input logic   flush_i,
    input id_ex_s id_ex_i,
    input id_ex_s id_ex_o
);

    hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (stall_i && !flush_i) |=> $stable(id_ex_o))
        else $error("ID/EX register changed while stalled.");

    bubble_after_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> (!id_ex_o.reg_wb_en && (id_ex_o.branch_sel == `BR_NONE)))
        else $error("ID/EX register holds no bubble after a flush.");

    load_when_free: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!stall_i && !flush_i) |=> (id_ex_o == $past(id_ex_i)))
        else $error("ID/EX register did not load the decoded bundle.");

endmodule

bind id_ex_stage_reg id_ex_properties u_properties (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .stall_i (stall_i),
    .flush_i (flush_i),
    .id_ex_i (id_ex_i),
    .id_ex_o (id_ex_o)
);

`default_nettype wire

//--- sim/id_ex_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module id_ex_tb import pipe_pkg::*; ();

    localparam int N_TESTS       = 6;
    localparam int MAX_STEPS     = 256;          // Per test, writes included.
    localparam int CLK_PERIOD_NS = 8;
    localparam int WATCHDOG_NS   = N_TESTS * MAX_STEPS * CLK_PERIOD_NS + 2000;

    typedef struct packed {
        ex_result_s  exp;
        logic        check_target;
        logic [31:0] due;                        // Cycle at which ex_o shows it.
    } check_item_s;

    logic        clk = 1'b0;
    logic        rst_n;
    instr_u      instr;
    logic [31:1] pc_in;
    logic        stall;
    logic        flush;
    rf_write_s   rf_wr;
    ex_result_s  ex_out;

    logic [31:0] model_regs [0:31];
    logic [31:1] pc;
    logic [31:0] lfsr_state = 32'h6e6e_422a;
    logic [31:0] cycle_cnt  = '0;
    check_item_s pending [$];
    check_item_s last_item  = '0;
    string       test_name;
    int          test_checks;
    int          test_errors;
    int          total_checks = 0;
    int          total_errors = 0;

    // Branch operand pairs: equal, less, greater, signed/unsigned split.
    logic [4:0]  pair_a [0:4] = '{5'd1, 5'd1, 5'd4, 5'd3, 5'd1};
    logic [4:0]  pair_b [0:4] = '{5'd2, 5'd4, 5'd1, 5'd1, 5'd3};

    id_ex_top DUT (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .instr_i (instr),
        .pc_i    (pc_in),
        .stall_i (stall),
        .flush_i (flush),
        .rf_wr_i (rf_wr),
        .ex_o    (ex_out)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 32'd1;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // Taps 32, 22, 2, 1.
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'b000:  r = alt ? (a - b) : (a + b);
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Expected execute output from the RV32I rules.
    function automatic ex_result_s ref_model(input logic [31:0] ins, input logic [31:1] pc_v,
                                             input logic [31:0] regs [0:31]);
        ex_result_s  r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pcf;
        logic [31:0] imm;
        logic [31:0] sum;
        logic [2:0]  f3;
        r   = '0;
        a   = regs[ins[19:15]];
        b   = regs[ins[24:20]];
        pcf = {pc_v, 1'b0};
        f3  = ins[14:12];
        case (ins[6:0])
            `OPC_OP: begin
                r.result = alu_ref(f3, ins[30], a, b);
                r.wb_en  = 1'b1;
                r.rd     = ins[11:7];
            end
            `OPC_OP_IMM: begin
                imm      = {{20{ins[31]}}, ins[31:20]};
                r.result = alu_ref(f3, (f3 == 3'b101) && ins[30], a, imm);
                r.wb_en  = 1'b1;
                r.rd     = ins[11:7];
            end
            `OPC_LUI, `OPC_AUIPC: begin
                imm      = {ins[31:12], 12'd0};
                r.result = (ins[6:0] == `OPC_LUI) ? imm : (pcf + imm);
                r.wb_en  = 1'b1;
                r.rd     = ins[11:7];
            end
            `OPC_JAL: begin
                imm             = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                sum             = pcf + imm;
                r.result        = pcf + 32'd4;
                r.wb_en         = 1'b1;
                r.rd            = ins[11:7];
                r.branch_taken  = 1'b1;
                r.branch_target = sum[31:1];
            end
            `OPC_BRANCH: begin
                imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                sum = pcf + imm;
                case (f3)
                    3'b000:  r.branch_taken = (a == b);
                    3'b001:  r.branch_taken = (a != b);
                    3'b100:  r.branch_taken = ($signed(a) < $signed(b));
                    3'b101:  r.branch_taken = ($signed(a) >= $signed(b));
                    3'b110:  r.branch_taken = (a < b);
                    3'b111:  r.branch_taken = (a >= b);
                    default: r.branch_taken = 1'b0;
                endcase
                r.branch_target = sum[31:1];
            end
            default: r = '0;                     // Bubble.
        endcase
        return r;
    endfunction

    task automatic report_mismatch(input string field, input logic [31:0] exp,
                                   input logic [31:0] act);
        test_errors++;
        $display("[FAIL] %s %s: expected %h, actual %h", test_name, field, exp, act);
    endtask

    task automatic compare_result(input check_item_s item);
        test_checks++;
        if (ex_out.wb_en !== item.exp.wb_en)
            report_mismatch("wb_en", 32'(item.exp.wb_en), 32'(ex_out.wb_en));
        if (ex_out.branch_taken !== item.exp.branch_taken)
            report_mismatch("branch_taken", 32'(item.exp.branch_taken),
                            32'(ex_out.branch_taken));
        if (item.exp.wb_en && (ex_out.result !== item.exp.result))
            report_mismatch("result", item.exp.result, ex_out.result);
        if (item.exp.wb_en && (ex_out.rd !== item.exp.rd))
            report_mismatch("rd", 32'(item.exp.rd), 32'(ex_out.rd));
        if (item.check_target && (ex_out.branch_target !== item.exp.branch_target))
            report_mismatch("branch_target", {item.exp.branch_target, 1'b0},
                            {ex_out.branch_target, 1'b0});
    endtask

    always @(negedge clk) begin : compare_proc
        check_item_s item;
        while ((pending.size() != 0) && (pending[0].due == cycle_cnt)) begin
            item = pending.pop_front();
            compare_result(item);
        end
    end

    // Register writes stall the pipeline so the held bundle stays put.
    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        @(negedge clk);
        stall      = 1'b1;
        flush      = 1'b0;
        rf_wr.en   = 1'b1;
        rf_wr.addr = addr;
        rf_wr.data = data;
        if (addr != 5'd0) model_regs[addr] = data;
    endtask

    task automatic step(input logic [31:0] word, input logic stall_v, input logic flush_v);
        check_item_s item;
        @(negedge clk);
        instr    = word;
        pc_in    = pc;
        stall    = stall_v;
        flush    = flush_v;
        rf_wr.en = 1'b0;
        if (flush_v) begin
            item = '0;
        end else if (stall_v) begin
            item = last_item;
        end else begin
            item.exp          = ref_model(word, pc, model_regs);
            item.check_target = (word[6:0] == `OPC_BRANCH) || (word[6:0] == `OPC_JAL);
        end
        item.due  = cycle_cnt + 32'd1;
        pending.push_back(item);
        last_item = item;
        pc        = pc + 31'd2;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        while (pending.size() != 0) @(negedge clk);
        $display("Test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    initial begin : watchdog_proc
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns.", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main_proc
        logic [11:0] imm12;
        rst_n = 1'b0;
        instr = enc_j(21'd8, 5'd1);                  // Writes back and jumps unless cleared.
        pc_in = '0;
        stall = 1'b0;
        flush = 1'b0;
        rf_wr = '0;
        pc    = 31'h0000_0200;
        for (int k = 0; k < 32; k++) model_regs[k] = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_state");
        test_checks++;
        if (ex_out.wb_en !== 1'b0) report_mismatch("wb_en", 32'd0, 32'(ex_out.wb_en));
        if (ex_out.branch_taken !== 1'b0)
            report_mismatch("branch_taken", 32'd0, 32'(ex_out.branch_taken));
        write_reg(5'd0, 32'hdead_beef);              // Must be ignored.
        for (int k = 1; k < 32; k++) write_reg(5'(k), rand_bits(32));
        for (int k = 0; k < 32; k++) begin
            step(enc_r(7'h00, 5'(k), 5'd0, 3'b000, 5'd1), 1'b0, 1'b0);
            step(enc_r(7'h00, 5'd0, 5'(k), 3'b000, 5'd2), 1'b0, 1'b0);
        end
        finish_test();

        start_test("alu_ops");
        for (int k = 1; k < 32; k++) write_reg(5'(k), rand_bits(32));
        for (int rep = 0; rep < 8; rep++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    if ((alt == 1) && (f3 != 0) && (f3 != 5)) continue;
                    step(enc_r((alt == 1) ? 7'h20 : 7'h00, 5'(rand_bits(5)), 5'(rand_bits(5)),
                               3'(f3), 5'(rand_bits(5))), 1'b0, 1'b0);
                    if ((alt == 1) && (f3 == 0)) continue;     // No subi.
                    if ((f3 == 1) || (f3 == 5)) begin
                        imm12 = {(alt == 1) ? 7'h20 : 7'h00, 5'(rand_bits(5))};
                    end else begin
                        imm12 = 12'(rand_bits(12));
                    end
                    step(enc_i(imm12, 5'(rand_bits(5)), 3'(f3), 5'(rand_bits(5))), 1'b0, 1'b0);
                end
            end
        end
        finish_test();

        start_test("upper_and_jal");
        pc = {30'(rand_bits(30)), 1'b0};
        for (int rep = 0; rep < 8; rep++) begin
            step({20'(rand_bits(20)), 5'(rand_bits(5)), `OPC_LUI}, 1'b0, 1'b0);
            step({20'(rand_bits(20)), 5'(rand_bits(5)), `OPC_AUIPC}, 1'b0, 1'b0);
            step(enc_j({20'(rand_bits(20)), 1'b0}, 5'(rand_bits(5))), 1'b0, 1'b0);
        end
        finish_test();

        start_test("branches");
        write_reg(5'd1, 32'd5);
        write_reg(5'd2, 32'd5);
        write_reg(5'd3, 32'hffff_fffd);              // -3, huge when unsigned.
        write_reg(5'd4, 32'd7);
        for (int f3 = 0; f3 < 8; f3++) begin
            if ((f3 == 2) || (f3 == 3)) continue;
            for (int p = 0; p < 5; p++) begin
                step(enc_b({12'(rand_bits(12)), 1'b0}, pair_b[p], pair_a[p], 3'(f3)),
                     1'b0, 1'b0);
            end
        end
        finish_test();

        start_test("stall");
        step(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd9), 1'b0, 1'b0);
        repeat (3) step(enc_i(12'(rand_bits(12)), 5'd4, 3'b100, 5'd10), 1'b1, 1'b0);
        step(enc_r(7'h20, 5'd4, 5'd1, 3'b000, 5'd11), 1'b0, 1'b0);
        finish_test();

        start_test("flush_bubble");
        step(enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd12), 1'b0, 1'b0);
        step(enc_j({20'(rand_bits(20)), 1'b0}, 5'd13), 1'b0, 1'b1);
        step(enc_r(7'h00, 5'd4, 5'd1, 3'b110, 5'd14), 1'b0, 1'b0);
        step(enc_j({20'(rand_bits(20)), 1'b0}, 5'd15), 1'b1, 1'b1);
        step({20'(rand_bits(20)), 5'd16, 7'b0000011}, 1'b0, 1'b0);   // Load, unsupported.
        step(32'hffff_ffff, 1'b0, 1'b0);
        finish_test();

        $display("Checks: %0d, errors: %0d", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module ex_alu import pipe_pkg::*; (
    input  id_ex_s     id_ex_i,
    output ex_result_s ex_o
);

    logic [`XLEN-1:0] pc_full;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_result;
    logic             cmp_eq;
    logic             cmp_lt;
    logic             cmp_ltu;
    logic             taken;
    logic [`XLEN-1:0] target;

    assign pc_full = {id_ex_i.pc, 1'b0};
    assign op_a    = (id_ex_i.op1_sel == `OP1_PC) ? pc_full : id_ex_i.rs1_value;

    // Jal links pc + 4.
    assign op_b  = (id_ex_i.branch_sel == `BR_JUMP) ? `XLEN'd4 :
                   (id_ex_i.op2_sel == `OP2_IMM) ? id_ex_i.imm_value : id_ex_i.rs2_value;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            `ALU_ADD:    alu_result = op_a + op_b;
            `ALU_SUB:    alu_result = op_a - op_b;
            `ALU_AND:    alu_result = op_a & op_b;
            `ALU_OR:     alu_result = op_a | op_b;
            `ALU_XOR:    alu_result = op_a ^ op_b;
            `ALU_SLL:    alu_result = op_a << shamt;
            `ALU_SRL:    alu_result = op_a >> shamt;
            `ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
            `ALU_SLT:    alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            `ALU_SLTU:   alu_result = {31'd0, op_a < op_b};
            `ALU_PASS_B: alu_result = op_b;
            default:     alu_result = '0;
        endcase
    end

    assign cmp_eq  = (id_ex_i.rs1_value == id_ex_i.rs2_value);
    assign cmp_lt  = ($signed(id_ex_i.rs1_value) < $signed(id_ex_i.rs2_value));
    assign cmp_ltu = (id_ex_i.rs1_value < id_ex_i.rs2_value);

    always_comb begin
        case (id_ex_i.branch_sel)
            `BR_BEQ:  taken = cmp_eq;
            `BR_BNE:  taken = !cmp_eq;
            `BR_BLT:  taken = cmp_lt;
            `BR_BGE:  taken = !cmp_lt;
            `BR_BLTU: taken = cmp_ltu;
            `BR_BGEU: taken = !cmp_ltu;
            `BR_JUMP: taken = 1'b1;
            default:  taken = 1'b0;                  // BR_NONE.
        endcase
    end

    assign target = pc_full + id_ex_i.imm_value;

    assign ex_o.result        = alu_result;
    assign ex_o.rd            = id_ex_i.rd;
    assign ex_o.wb_en         = id_ex_i.reg_wb_en;
    assign ex_o.branch_taken  = taken;
    assign ex_o.branch_target = target[`XLEN-1:1];

endmodule

`default_nettype wire

//--- verilog/id_ex_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module id_ex_stage_reg import pipe_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   stall_i,
    input  logic   flush_i,
    input  id_ex_s id_ex_i,
    output id_ex_s id_ex_o
);

    localparam id_ex_s BUBBLE = '{
        pc:         '0,
        rs1_value:  '0,
        rs2_value:  '0,
        imm_value:  '0,
        op1_sel:    `OP1_RS1,
        op2_sel:    `OP2_RS2,
        alu_op:     `ALU_ADD,
        branch_sel: `BR_NONE,
        reg_wb_en:  1'b0,
        rd:         '0
    };

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_o <= BUBBLE;
        end else if (flush_i) begin
            id_ex_o <= BUBBLE;                       // Flush wins over stall.
        end else if (!stall_i) begin
            id_ex_o <= id_ex_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/id_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module id_ex_top import pipe_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  instr_u           instr_i,
    input  logic [`XLEN-1:1] pc_i,
    input  logic             stall_i,
    input  logic             flush_i,
    input  rf_write_s        rf_wr_i,
    output ex_result_s       ex_o
);

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_value;
    logic [`XLEN-1:0]       rs2_value;
    id_ex_s                 id_bundle;
    id_ex_s                 ex_bundle;

    instr_decoder u_decoder (
        .instr_i     (instr_i),
        .pc_i        (pc_i),
        .rs1_value_i (rs1_value),
        .rs2_value_i (rs2_value),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .id_ex_o     (id_bundle)
    );

    reg_file u_reg_file (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rs1_addr_i  (rs1_addr),
        .rs2_addr_i  (rs2_addr),
        .wr_i        (rf_wr_i),
        .rs1_value_o (rs1_value),
        .rs2_value_o (rs2_value)
    );

    id_ex_stage_reg u_id_ex (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .id_ex_i (id_bundle),
        .id_ex_o (ex_bundle)
    );

    ex_alu u_ex_alu (
        .id_ex_i (ex_bundle),
        .ex_o    (ex_o)
    );

endmodule

`default_nettype wire

//--- verilog/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module instr_decoder import pipe_pkg::*; (
    input  instr_u                 instr_i,
    input  logic [`XLEN-1:1]       pc_i,
    input  logic [`XLEN-1:0]       rs1_value_i,
    input  logic [`XLEN-1:0]       rs2_value_i,
    output logic [`REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] rs2_addr_o,
    output id_ex_s                 id_ex_o
);

    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic             imm_sr_alt;

    function automatic logic [`ALU_OP_W-1:0] alu_decode(input logic [2:0] funct3,
                                                         input logic       alt);
        case (funct3)
            `F3_ADD_SUB: alu_decode = alt ? `ALU_SUB : `ALU_ADD;
            `F3_SLL:     alu_decode = `ALU_SLL;
            `F3_SLT:     alu_decode = `ALU_SLT;
            `F3_SLTU:    alu_decode = `ALU_SLTU;
            `F3_XOR:     alu_decode = `ALU_XOR;
            `F3_SR:      alu_decode = alt ? `ALU_SRA : `ALU_SRL;
            `F3_OR:      alu_decode = `ALU_OR;
            default:     alu_decode = `ALU_AND;
        endcase
    endfunction

    assign rs1_addr_o = instr_i.r_fmt.rs1;
    assign rs2_addr_o = instr_i.r_fmt.rs2;

    assign imm_i = {{20{instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
    assign imm_b = {{19{instr_i.sb_fmt.imm_hi[6]}}, instr_i.sb_fmt.imm_hi[6],
                    instr_i.sb_fmt.imm_lo[0], instr_i.sb_fmt.imm_hi[5:0],
                    instr_i.sb_fmt.imm_lo[4:1], 1'b0};
    assign imm_u = {instr_i.uj_fmt.imm, 12'd0};
    assign imm_j = {{11{instr_i.uj_fmt.imm[19]}}, instr_i.uj_fmt.imm[19],
                    instr_i.uj_fmt.imm[7:0], instr_i.uj_fmt.imm[8],
                    instr_i.uj_fmt.imm[18:9], 1'b0};

    // Only srai takes the funct7 bit; addi has no subtract form.
    assign imm_sr_alt = (instr_i.i_fmt.funct3 == `F3_SR) && instr_i.r_fmt.funct7[5];

    always_comb begin
        id_ex_o            = '0;
        id_ex_o.pc         = pc_i;
        id_ex_o.rs1_value  = rs1_value_i;
        id_ex_o.rs2_value  = rs2_value_i;
        id_ex_o.alu_op     = `ALU_ADD;
        id_ex_o.branch_sel = `BR_NONE;
        case (instr_i.r_fmt.opcode)
            `OPC_OP: begin
                id_ex_o.op1_sel   = `OP1_RS1;
                id_ex_o.op2_sel   = `OP2_RS2;
                id_ex_o.alu_op    = alu_decode(instr_i.r_fmt.funct3, instr_i.r_fmt.funct7[5]);
                id_ex_o.reg_wb_en = 1'b1;
                id_ex_o.rd        = instr_i.r_fmt.rd;
            end
            `OPC_OP_IMM: begin
                id_ex_o.imm_value = imm_i;
                id_ex_o.op2_sel   = `OP2_IMM;
                id_ex_o.alu_op    = alu_decode(instr_i.i_fmt.funct3, imm_sr_alt);
                id_ex_o.reg_wb_en = 1'b1;
                id_ex_o.rd        = instr_i.i_fmt.rd;
            end
            `OPC_LUI: begin
                id_ex_o.imm_value = imm_u;
                id_ex_o.op2_sel   = `OP2_IMM;
                id_ex_o.alu_op    = `ALU_PASS_B;
                id_ex_o.reg_wb_en = 1'b1;
                id_ex_o.rd        = instr_i.uj_fmt.rd;
            end
            `OPC_AUIPC: begin
                id_ex_o.imm_value = imm_u;
                id_ex_o.op1_sel   = `OP1_PC;
                id_ex_o.op2_sel   = `OP2_IMM;
                id_ex_o.reg_wb_en = 1'b1;
                id_ex_o.rd        = instr_i.uj_fmt.rd;
            end
            `OPC_JAL: begin
                id_ex_o.imm_value  = imm_j;          // Target offset; link uses pc + 4.
                id_ex_o.op1_sel    = `OP1_PC;
                id_ex_o.op2_sel    = `OP2_IMM;
                id_ex_o.branch_sel = `BR_JUMP;
                id_ex_o.reg_wb_en  = 1'b1;
                id_ex_o.rd         = instr_i.uj_fmt.rd;
            end
            `OPC_BRANCH: begin
                id_ex_o.imm_value = imm_b;
                case (instr_i.sb_fmt.funct3)
                    `BR_BEQ, `BR_BNE, `BR_BLT, `BR_BGE, `BR_BLTU, `BR_BGEU:
                        id_ex_o.branch_sel = instr_i.sb_fmt.funct3;
                    default:
                        id_ex_o.branch_sel = `BR_NONE;
                endcase
            end
            default: begin
                id_ex_o.branch_sel = `BR_NONE;       // Unsupported, bubble.
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/pipe_pkg.sv
`default_nettype none

`include "pipe_consts.svh"

package pipe_pkg;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [6:0]             imm_hi;     // imm[12], imm[10:5].
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;     // imm[4:1], imm[11].
        logic [6:0]             opcode;
    } sb_fmt_s;

    typedef struct packed {
        logic [19:0]            imm;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } uj_fmt_s;

    typedef union packed {
        r_fmt_s  r_fmt;
        i_fmt_s  i_fmt;
        sb_fmt_s sb_fmt;
        uj_fmt_s uj_fmt;
    } instr_u;

    typedef struct packed {
        logic [`XLEN-1:1]       pc;
        logic [`XLEN-1:0]       rs1_value;
        logic [`XLEN-1:0]       rs2_value;
        logic [`XLEN-1:0]       imm_value;
        logic                   op1_sel;
        logic                   op2_sel;
        logic [`ALU_OP_W-1:0]   alu_op;
        logic [`BR_SEL_W-1:0]   branch_sel;
        logic                   reg_wb_en;
        logic [`REG_ADDR_W-1:0] rd;
    } id_ex_s;

    typedef struct packed {
        logic [`XLEN-1:0]       result;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   wb_en;
        logic                   branch_taken;
        logic [`XLEN-1:1]       branch_target;
    } ex_result_s;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } rf_write_s;

endpackage

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_consts.svh"

module reg_file import pipe_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    input  rf_write_s              wr_i,
    output logic [`XLEN-1:0]       rs1_value_o,
    output logic [`XLEN-1:0]       rs2_value_o
);

    logic [`XLEN-1:0] regs [1:31];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.en && (wr_i.addr != '0)) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // No write bypass.
    assign rs1_value_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_value_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire
